//--- design/rd_dma_cfg_pkg.sv
// Geometry constants of the read DMA engine and its two-bank scratchpad
`default_nettype none

package rd_dma_cfg_pkg;

  // Accelerator streams
  localparam int ACCEL_COUNT = 4;
  localparam int DEST_WIDTH  = 2;

  // One line is one beat, 16 bytes
  localparam int DATA_WIDTH = 128;
  localparam int MASK_BITS  = 4;

  // Descriptor fields
  localparam int ADDR_WIDTH = 12;
  localparam int LEN_WIDTH  = 10;

  // Line view of the scratchpad
  localparam int LINE_ADDR_WIDTH = ADDR_WIDTH - MASK_BITS;
  localparam int LINE_CNT_WIDTH  = LEN_WIDTH - MASK_BITS;

  // Even lines sit in bank 0 and odd lines in bank 1
  localparam int BANK_ADDR_WIDTH = LINE_ADDR_WIDTH - 1;

  // Output buffering and its credit counter
  localparam int FIFO_LINES   = 2;
  localparam int CREDIT_WIDTH = 2;

  // Read enable to data, in cycles
  localparam int MEM_LATENCY = 2;

endpackage

`default_nettype wire

//--- design/rd_dma_types_pkg.sv
// Packed structs carried between the blocks of the read DMA engine
`default_nettype none

package rd_dma_types_pkg;

  // Descriptor as it arrives from the host side
  typedef struct packed {
    logic [rd_dma_cfg_pkg::DEST_WIDTH-1:0] accel_id;
    logic [rd_dma_cfg_pkg::ADDR_WIDTH-1:0] addr;
    logic [rd_dma_cfg_pkg::LEN_WIDTH-1:0]  len;
  } desc_t;

  // Line request, also the layout of one active entry
  typedef struct packed {
    logic [rd_dma_cfg_pkg::LINE_ADDR_WIDTH-1:0] line_addr;
    logic [rd_dma_cfg_pkg::LINE_CNT_WIDTH-1:0]  count;
    logic [rd_dma_cfg_pkg::MASK_BITS-1:0]       final_ptr;
    logic [rd_dma_cfg_pkg::MASK_BITS-1:0]       offset;
  } line_req_t;

  typedef struct packed {
    logic                                       en;
    logic [rd_dma_cfg_pkg::BANK_ADDR_WIDTH-1:0] addr;
  } bank_rd_t;

  // Travels alongside a bank read until the data returns
  typedef struct packed {
    logic [rd_dma_cfg_pkg::DEST_WIDTH-1:0] dest;
    logic                                  last;
    logic [rd_dma_cfg_pkg::MASK_BITS-1:0]  ptr;
    logic [rd_dma_cfg_pkg::MASK_BITS-1:0]  offset;
    logic                                  bank;
  } rd_meta_t;

  // user holds the index of the last valid byte in the beat
  typedef struct packed {
    logic [rd_dma_cfg_pkg::DATA_WIDTH-1:0] data;
    logic [rd_dma_cfg_pkg::MASK_BITS-1:0]  user;
    logic                                  last;
  } beat_t;

endpackage

`default_nettype wire

//--- design/desc_parse.sv
// Descriptor register that turns a byte address and length into a line request
`timescale 1ns/1ps
`default_nettype none

module desc_parse (
  input  wire                                   clk,
  input  wire                                   rst,
  input  wire rd_dma_types_pkg::desc_t          desc,
  input  wire                                   desc_valid,
  output rd_dma_types_pkg::line_req_t           req,
  output logic [rd_dma_cfg_pkg::DEST_WIDTH-1:0] req_dest,
  output logic                                  req_valid
);

  logic [rd_dma_cfg_pkg::MASK_BITS-1:0]      rem_bytes;
  logic [rd_dma_cfg_pkg::LINE_CNT_WIDTH-1:0] whole_lines;

  assign rem_bytes   = desc.len[rd_dma_cfg_pkg::MASK_BITS-1:0];
  assign whole_lines = desc.len[rd_dma_cfg_pkg::LEN_WIDTH-1:rd_dma_cfg_pkg::MASK_BITS];

  always_ff @(posedge clk) begin
    req.line_addr <= desc.addr[rd_dma_cfg_pkg::ADDR_WIDTH-1:rd_dma_cfg_pkg::MASK_BITS];
    req.offset    <= desc.addr[rd_dma_cfg_pkg::MASK_BITS-1:0];
    // A partial tail costs one more line
    req.count     <= (rem_bytes == '0) ? whole_lines : whole_lines + 1'b1;
    // Zero remainder wraps to 15, a full last line
    req.final_ptr <= rem_bytes - 1'b1;
    req_dest      <= desc.accel_id;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= desc_valid;
    end
  end

endmodule

`default_nettype wire

//--- design/channel_state.sv
// Per-accelerator stop latch, busy flag and sticky descriptor error
`timescale 1ns/1ps
`default_nettype none

module channel_state (
  input  wire                                    clk,
  input  wire                                    rst,
  input  wire rd_dma_types_pkg::desc_t           desc,
  input  wire                                    desc_valid,
  input  wire                                    req_valid,
  input  wire [rd_dma_cfg_pkg::DEST_WIDTH-1:0]   req_dest,
  input  wire [rd_dma_cfg_pkg::ACCEL_COUNT-1:0]  accel_stop,
  input  wire [rd_dma_cfg_pkg::ACCEL_COUNT-1:0]  last_done,
  output logic [rd_dma_cfg_pkg::ACCEL_COUNT-1:0] stop_lat,
  output logic [rd_dma_cfg_pkg::ACCEL_COUNT-1:0] accel_busy,
  output logic [rd_dma_cfg_pkg::ACCEL_COUNT-1:0] desc_error
);

  logic [rd_dma_cfg_pkg::ACCEL_COUNT-1:0] req_hot;
  logic [rd_dma_cfg_pkg::ACCEL_COUNT-1:0] desc_hot;

  // One-hot decode of the registered request and of the raw descriptor
  assign req_hot  = {{(rd_dma_cfg_pkg::ACCEL_COUNT-1){1'b0}}, req_valid} << req_dest;
  assign desc_hot = {{(rd_dma_cfg_pkg::ACCEL_COUNT-1){1'b0}}, desc_valid} << desc.accel_id;

  // Stop pulses stick until the next descriptor for that accelerator
  always_ff @(posedge clk) begin
    if (rst) begin
      stop_lat <= '0;
    end else begin
      stop_lat <= (stop_lat | accel_stop) & ~desc_hot;
    end
  end

  // Busy spans from the registered request to the last beat handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      accel_busy <= '0;
    end else begin
      accel_busy <= (accel_busy | req_hot) & ~stop_lat & ~last_done;
    end
  end

  // A descriptor for a busy accelerator is flagged until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      desc_error <= '0;
    end else begin
      desc_error <= desc_error | (desc_hot & accel_busy);
    end
  end

endmodule

`default_nettype wire

//--- design/line_sched.sv
// Active entry table, round-robin arbiter and paired bank read issue
`timescale 1ns/1ps
`default_nettype none

module line_sched (
  input  wire                                   clk,
  input  wire                                   rst,
  input  wire rd_dma_types_pkg::line_req_t      req,
  input  wire [rd_dma_cfg_pkg::DEST_WIDTH-1:0]  req_dest,
  input  wire                                   req_valid,
  input  wire [rd_dma_cfg_pkg::ACCEL_COUNT-1:0] stop_lat,
  input  wire [rd_dma_cfg_pkg::ACCEL_COUNT-1:0] credit_ok,
  output rd_dma_types_pkg::bank_rd_t            bank0_rd,
  output rd_dma_types_pkg::bank_rd_t            bank1_rd,
  output rd_dma_types_pkg::rd_meta_t            meta,
  output logic                                  meta_valid,
  output logic                                  issue_valid,
  output logic [rd_dma_cfg_pkg::DEST_WIDTH-1:0] issue_dest
);

  rd_dma_types_pkg::line_req_t entry_mem [rd_dma_cfg_pkg::ACCEL_COUNT];
  logic [rd_dma_cfg_pkg::ACCEL_COUNT-1:0]     act_valid;
  rd_dma_types_pkg::line_req_t                sel;
  rd_dma_types_pkg::line_req_t                next_entry;
  logic                                       sel_last;
  logic                                       act_issue;
  logic [rd_dma_cfg_pkg::ACCEL_COUNT-1:0]     req_hot;
  logic [rd_dma_cfg_pkg::ACCEL_COUNT-1:0]     set_hot;
  logic [rd_dma_cfg_pkg::ACCEL_COUNT-1:0]     clr_hot;
  logic [rd_dma_cfg_pkg::ACCEL_COUNT-1:0]     arb_request;
  logic [rd_dma_cfg_pkg::ACCEL_COUNT-1:0]     masked;
  logic [rd_dma_cfg_pkg::ACCEL_COUNT-1:0]     rr_mask;
  logic [rd_dma_cfg_pkg::ACCEL_COUNT-1:0]     grant_hot;
  logic                                       grant_v;
  logic [rd_dma_cfg_pkg::DEST_WIDTH-1:0]      grant_enc;
  logic                                       pick_v;
  logic [rd_dma_cfg_pkg::DEST_WIDTH-1:0]      pick;

  assign req_hot   = {{(rd_dma_cfg_pkg::ACCEL_COUNT-1){1'b0}}, req_valid} << req_dest;
  assign grant_hot = {{(rd_dma_cfg_pkg::ACCEL_COUNT-1){1'b0}}, grant_v} << grant_enc;

  // A granted entry still being written back must sit out one round,
  // unless a fresh request took the slot and the grant was dropped
  assign arb_request = act_valid & credit_ok & ~stop_lat & ~(req_valid ? '0 : grant_hot);
  assign masked      = arb_request & rr_mask;

  // Lowest index above the last grant wins, else lowest overall
  always_comb begin
    pick_v = 1'b0;
    pick   = '0;
    for (int i = rd_dma_cfg_pkg::ACCEL_COUNT - 1; i >= 0; i--) begin
      if (masked[i]) begin
        pick_v = 1'b1;
        pick   = i[rd_dma_cfg_pkg::DEST_WIDTH-1:0];
      end
    end
    if (!pick_v) begin
      for (int i = rd_dma_cfg_pkg::ACCEL_COUNT - 1; i >= 0; i--) begin
        if (arb_request[i]) begin
          pick_v = 1'b1;
          pick   = i[rd_dma_cfg_pkg::DEST_WIDTH-1:0];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      grant_v   <= 1'b0;
      grant_enc <= '0;
      rr_mask   <= '1;
    end else begin
      grant_v <= pick_v;
      if (pick_v) begin
        grant_enc <= pick;
        rr_mask   <= {{(rd_dma_cfg_pkg::ACCEL_COUNT-1){1'b1}}, 1'b0} << pick;
      end
    end
  end

  // Fresh requests take priority over the granted entry
  assign act_issue   = grant_v && act_valid[grant_enc] && !stop_lat[grant_enc] && !req_valid;
  assign sel         = req_valid ? req : entry_mem[grant_enc];
  assign issue_valid = req_valid || act_issue;
  assign issue_dest  = req_valid ? req_dest : grant_enc;
  assign sel_last    = (sel.count == (rd_dma_cfg_pkg::LINE_CNT_WIDTH)'(1));

  always_comb begin
    next_entry           = sel;
    next_entry.line_addr = sel.line_addr + 1'b1;
    next_entry.count     = sel.count - 1'b1;
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      entry_mem[issue_dest] <= next_entry;
    end
  end

  assign set_hot = (req_valid && !sel_last) ? req_hot : '0;
  assign clr_hot = (act_issue && sel_last) ? grant_hot : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      act_valid <= '0;
    end else begin
      act_valid <= (act_valid | set_hot) & ~clr_hot & ~stop_lat;
    end
  end

  // Issued line from its own bank, following line from the other one
  always_ff @(posedge clk) begin
    bank0_rd.en   <= issue_valid;
    bank1_rd.en   <= issue_valid;
    bank0_rd.addr <= sel.line_addr[0] ?
                     next_entry.line_addr[rd_dma_cfg_pkg::LINE_ADDR_WIDTH-1:1] :
                     sel.line_addr[rd_dma_cfg_pkg::LINE_ADDR_WIDTH-1:1];
    bank1_rd.addr <= sel.line_addr[rd_dma_cfg_pkg::LINE_ADDR_WIDTH-1:1];
    meta.dest     <= issue_dest;
    meta.last     <= sel_last;
    meta.ptr      <= sel_last ? sel.final_ptr : '1;
    meta.offset   <= sel.offset;
    meta.bank     <= sel.line_addr[0];
    meta_valid    <= issue_valid;
    if (rst) begin
      bank0_rd.en <= 1'b0;
      bank1_rd.en <= 1'b0;
      meta_valid  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- design/line_align.sv
// Read metadata delay, bank ordering and byte shift into output beats
`timescale 1ns/1ps
`default_nettype none

module line_align (
  input  wire                                   clk,
  input  wire                                   rst,
  input  wire rd_dma_types_pkg::rd_meta_t       meta,
  input  wire                                   meta_valid,
  input  wire [rd_dma_cfg_pkg::DATA_WIDTH-1:0]  bank0_data,
  input  wire [rd_dma_cfg_pkg::DATA_WIDTH-1:0]  bank1_data,
  output rd_dma_types_pkg::beat_t               beat,
  output logic                                  beat_valid,
  output logic [rd_dma_cfg_pkg::DEST_WIDTH-1:0] beat_dest
);

  rd_dma_types_pkg::rd_meta_t                 meta_pipe [rd_dma_cfg_pkg::MEM_LATENCY];
  logic [rd_dma_cfg_pkg::MEM_LATENCY-1:0]     valid_pipe;
  rd_dma_types_pkg::rd_meta_t                 meta_now;
  logic [2*rd_dma_cfg_pkg::DATA_WIDTH-1:0]    pair;
  logic [2*rd_dma_cfg_pkg::DATA_WIDTH-1:0]    shifted;

  // Match the scratchpad latency so meta lines up with its data
  always_ff @(posedge clk) begin
    meta_pipe[0] <= meta;
    for (int i = 1; i < rd_dma_cfg_pkg::MEM_LATENCY; i++) begin
      meta_pipe[i] <= meta_pipe[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe[0] <= meta_valid;
      for (int i = 1; i < rd_dma_cfg_pkg::MEM_LATENCY; i++) begin
        valid_pipe[i] <= valid_pipe[i-1];
      end
    end
  end

  assign meta_now = meta_pipe[rd_dma_cfg_pkg::MEM_LATENCY-1];

  // The issued line goes low, the following line high
  assign pair    = meta_now.bank ? {bank0_data, bank1_data} : {bank1_data, bank0_data};
  assign shifted = pair >> {meta_now.offset, 3'b000};

  always_ff @(posedge clk) begin
    beat.data  <= shifted[rd_dma_cfg_pkg::DATA_WIDTH-1:0];
    beat.user  <= meta_now.ptr;
    beat.last  <= meta_now.last;
    beat_dest  <= meta_now.dest;
    beat_valid <= valid_pipe[rd_dma_cfg_pkg::MEM_LATENCY-1];
    if (rst) begin
      beat_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- design/accel_fifo.sv
// Per-accelerator output FIFO guarded by an issue credit counter
`timescale 1ns/1ps
`default_nettype none

module accel_fifo (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       clear,
  input  wire                       issue,
  input  wire                       wr_valid,
  input  wire rd_dma_types_pkg::beat_t wr_beat,
  output rd_dma_types_pkg::beat_t   m_beat,
  output logic                      m_valid,
  input  wire                       m_ready,
  output logic                      credit_ok
);

  rd_dma_types_pkg::beat_t store [rd_dma_cfg_pkg::FIFO_LINES];
  logic [$clog2(rd_dma_cfg_pkg::FIFO_LINES)-1:0] wr_ptr;
  logic [$clog2(rd_dma_cfg_pkg::FIFO_LINES)-1:0] rd_ptr;
  logic [rd_dma_cfg_pkg::CREDIT_WIDTH-1:0]       fill;
  logic [rd_dma_cfg_pkg::CREDIT_WIDTH-1:0]       credit;
  logic                                          push;
  logic                                          pop;

  // Credits keep pushes from ever finding the FIFO full
  assign push      = wr_valid && !clear;
  assign pop       = m_valid && m_ready;
  assign m_valid   = (fill != '0);
  assign m_beat    = store[rd_ptr];
  assign credit_ok = (credit < (rd_dma_cfg_pkg::CREDIT_WIDTH)'(rd_dma_cfg_pkg::FIFO_LINES));

  always_ff @(posedge clk) begin
    if (push) begin
      store[wr_ptr] <= wr_beat;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
      credit <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      // Lines in flight plus lines stored
      case ({issue, pop})
        2'b10:   credit <= credit + 1'b1;
        2'b01:   credit <= credit - 1'b1;
        default: credit <= credit;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/accel_rd_dma.sv
// Top level of the scratchpad read DMA for a group of accelerator streams
`timescale 1ns/1ps
`default_nettype none

module accel_rd_dma (
  input  wire                                   clk,
  input  wire                                   rst,
  input  wire rd_dma_types_pkg::desc_t          desc,
  input  wire                                   desc_valid,
  input  wire [rd_dma_cfg_pkg::ACCEL_COUNT-1:0] accel_stop,
  output wire [rd_dma_cfg_pkg::ACCEL_COUNT-1:0] accel_busy,
  output wire [rd_dma_cfg_pkg::ACCEL_COUNT-1:0] desc_error,
  output wire rd_dma_types_pkg::bank_rd_t       bank0_rd,
  output wire rd_dma_types_pkg::bank_rd_t       bank1_rd,
  input  wire [rd_dma_cfg_pkg::DATA_WIDTH-1:0]  bank0_data,
  input  wire [rd_dma_cfg_pkg::DATA_WIDTH-1:0]  bank1_data,
  output wire rd_dma_types_pkg::beat_t [rd_dma_cfg_pkg::ACCEL_COUNT-1:0] m_beat,
  output wire [rd_dma_cfg_pkg::ACCEL_COUNT-1:0] m_valid,
  input  wire [rd_dma_cfg_pkg::ACCEL_COUNT-1:0] m_ready
);

  rd_dma_types_pkg::line_req_t            req;
  logic [rd_dma_cfg_pkg::DEST_WIDTH-1:0]  req_dest;
  logic                                   req_valid;
  logic [rd_dma_cfg_pkg::ACCEL_COUNT-1:0] stop_lat;
  logic [rd_dma_cfg_pkg::ACCEL_COUNT-1:0] last_done;
  logic [rd_dma_cfg_pkg::ACCEL_COUNT-1:0] credit_ok;
  rd_dma_types_pkg::rd_meta_t             meta;
  logic                                   meta_valid;
  logic                                   issue_valid;
  logic [rd_dma_cfg_pkg::DEST_WIDTH-1:0]  issue_dest;
  logic [rd_dma_cfg_pkg::ACCEL_COUNT-1:0] issue_hot;
  rd_dma_types_pkg::beat_t                beat;
  logic                                   beat_valid;
  logic [rd_dma_cfg_pkg::DEST_WIDTH-1:0]  beat_dest;
  logic [rd_dma_cfg_pkg::ACCEL_COUNT-1:0] beat_hot;

  desc_parse i_desc_parse (
    .clk, .rst, .desc, .desc_valid, .req, .req_dest, .req_valid
  );

  channel_state i_channel_state (
    .clk, .rst, .desc, .desc_valid, .req_valid, .req_dest, .accel_stop,
    .last_done, .stop_lat, .accel_busy, .desc_error
  );

  line_sched i_line_sched (
    .clk, .rst, .req, .req_dest, .req_valid, .stop_lat, .credit_ok,
    .bank0_rd, .bank1_rd, .meta, .meta_valid, .issue_valid, .issue_dest
  );

  line_align i_line_align (
    .clk, .rst, .meta, .meta_valid, .bank0_data, .bank1_data,
    .beat, .beat_valid, .beat_dest
  );

  // Route issue credits and returning beats to their stream
  assign issue_hot = {{(rd_dma_cfg_pkg::ACCEL_COUNT-1){1'b0}}, issue_valid} << issue_dest;
  assign beat_hot  = {{(rd_dma_cfg_pkg::ACCEL_COUNT-1){1'b0}}, beat_valid} << beat_dest;

  for (genvar i = 0; i < rd_dma_cfg_pkg::ACCEL_COUNT; i++) begin : g_stream
    accel_fifo i_accel_fifo (
      .clk       (clk),
      .rst       (rst),
      .clear     (stop_lat[i]),
      .issue     (issue_hot[i]),
      .wr_valid  (beat_hot[i]),
      .wr_beat   (beat),
      .m_beat    (m_beat[i]),
      .m_valid   (m_valid[i]),
      .m_ready   (m_ready[i]),
      .credit_ok (credit_ok[i])
    );
    // Final beat accepted by the accelerator
    assign last_done[i] = m_valid[i] && m_ready[i] && m_beat[i].last;
  end

endmodule

`default_nettype wire

//--- sim/spad_model.sv
// Two-bank scratchpad model with even lines in bank 0, odd lines in bank 1
`timescale 1ns/1ps
`default_nettype none

module spad_model (
  input  wire                                   clk,
  input  wire rd_dma_types_pkg::bank_rd_t       bank0_rd,
  input  wire rd_dma_types_pkg::bank_rd_t       bank1_rd,
  output logic [rd_dma_cfg_pkg::DATA_WIDTH-1:0] bank0_data,
  output logic [rd_dma_cfg_pkg::DATA_WIDTH-1:0] bank1_data
);

  logic [rd_dma_cfg_pkg::DATA_WIDTH-1:0] pipe0 [rd_dma_cfg_pkg::MEM_LATENCY];
  logic [rd_dma_cfg_pkg::DATA_WIDTH-1:0] pipe1 [rd_dma_cfg_pkg::MEM_LATENCY];

  // Each byte holds the low byte of its address times 7, plus 3
  function automatic logic [rd_dma_cfg_pkg::DATA_WIDTH-1:0] line_bytes(
    input logic [rd_dma_cfg_pkg::BANK_ADDR_WIDTH-1:0] word,
    input logic                                       bank
  );
    logic [rd_dma_cfg_pkg::ADDR_WIDTH-1:0] byte_addr;
    logic [rd_dma_cfg_pkg::DATA_WIDTH-1:0] line;
    line = '0;
    for (int i = 0; i < 16; i++) begin
      byte_addr = {word, bank, rd_dma_cfg_pkg::MASK_BITS'(i)};
      line[8*i +: 8] = byte_addr[7:0] * 8'd7 + 8'd3;
    end
    return line;
  endfunction

  // Read data leaves the last stage MEM_LATENCY cycles after the enable
  always @(posedge clk) begin
    if (bank0_rd.en) begin
      pipe0[0] <= line_bytes(bank0_rd.addr, 1'b0);
    end
    if (bank1_rd.en) begin
      pipe1[0] <= line_bytes(bank1_rd.addr, 1'b1);
    end
    for (int i = 1; i < rd_dma_cfg_pkg::MEM_LATENCY; i++) begin
      pipe0[i] <= pipe0[i-1];
      pipe1[i] <= pipe1[i-1];
    end
  end

  assign bank0_data = pipe0[rd_dma_cfg_pkg::MEM_LATENCY-1];
  assign bank1_data = pipe1[rd_dma_cfg_pkg::MEM_LATENCY-1];

endmodule

`default_nettype wire

//--- sim/tb_accel_rd_dma.sv
// Directed testbench for the read DMA with a scratchpad model and beat scoreboard
`timescale 1ns/1ps
`default_nettype none

module tb_accel_rd_dma;

  localparam int ACCELS = rd_dma_cfg_pkg::ACCEL_COUNT;
  // Five short tests finish in well under a thousand cycles
  localparam int MAX_CYCLES = 20000;

  logic                                           clk;
  logic                                           rst;
  rd_dma_types_pkg::desc_t                        desc;
  logic                                           desc_valid;
  logic [ACCELS-1:0]                              accel_stop;
  logic [ACCELS-1:0]                              accel_busy;
  logic [ACCELS-1:0]                              desc_error;
  rd_dma_types_pkg::bank_rd_t                     bank0_rd;
  rd_dma_types_pkg::bank_rd_t                     bank1_rd;
  logic [rd_dma_cfg_pkg::DATA_WIDTH-1:0]          bank0_data;
  logic [rd_dma_cfg_pkg::DATA_WIDTH-1:0]          bank1_data;
  rd_dma_types_pkg::beat_t [ACCELS-1:0]           m_beat;
  logic [ACCELS-1:0]                              m_valid;
  logic [ACCELS-1:0]                              m_ready;

  // Scoreboard state per accelerator
  logic [rd_dma_cfg_pkg::ADDR_WIDTH-1:0] exp_addr [ACCELS];
  logic [rd_dma_cfg_pkg::LEN_WIDTH-1:0]  exp_len [ACCELS];
  int                                    exp_beats [ACCELS];
  int                                    got_beats [ACCELS];
  logic [ACCELS-1:0]                     ignore_beats;

  logic              ready_random;
  logic [ACCELS-1:0] ready_fixed;
  logic [7:0]        lfsr_state;
  int                cycle_count;
  int                error_count;
  int                pass_count;
  int                fail_count;
  int                errors_before;

  accel_rd_dma i_dut (
    .clk, .rst, .desc, .desc_valid, .accel_stop, .accel_busy, .desc_error,
    .bank0_rd, .bank1_rd, .bank0_data, .bank1_data, .m_beat, .m_valid, .m_ready
  );

  spad_model i_spad (
    .clk, .bank0_rd, .bank1_rd, .bank0_data, .bank1_data
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Fibonacci LFSR, taps for x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  // Sixteen bytes starting at addr, each its low address byte times 7 plus 3
  function automatic logic [rd_dma_cfg_pkg::DATA_WIDTH-1:0] expected_line(
    input logic [rd_dma_cfg_pkg::ADDR_WIDTH-1:0] addr
  );
    logic [rd_dma_cfg_pkg::ADDR_WIDTH-1:0] byte_addr;
    logic [rd_dma_cfg_pkg::DATA_WIDTH-1:0] line;
    line = '0;
    for (int j = 0; j < 16; j++) begin
      byte_addr = addr + rd_dma_cfg_pkg::ADDR_WIDTH'(j);
      line[8*j +: 8] = byte_addr[7:0] * 8'd7 + 8'd3;
    end
    return line;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // Compare one accepted beat with the next expected one
  task automatic check_beat(input int a);
    logic [rd_dma_cfg_pkg::ADDR_WIDTH-1:0] beat_addr;
    logic [rd_dma_cfg_pkg::MASK_BITS-1:0]  exp_user;
    logic                                  exp_last;
    if (got_beats[a] >= exp_beats[a]) begin
      $display("Accel %0d delivered a beat beyond its transfer at %0t", a, $time);
      error_count++;
    end else begin
      beat_addr = exp_addr[a] + rd_dma_cfg_pkg::ADDR_WIDTH'(16 * got_beats[a]);
      exp_last  = (got_beats[a] == exp_beats[a] - 1);
      // Final pointer is the remainder minus one, 15 for a full line
      exp_user  = exp_last ? rd_dma_cfg_pkg::MASK_BITS'(exp_len[a] - 1) : 4'hf;
      if (m_beat[a].data !== expected_line(beat_addr)) begin
        $display("Fail %0t: accel %0d beat %0d data %h, expected %h", $time, a,
                 got_beats[a], m_beat[a].data, expected_line(beat_addr));
        error_count++;
      end
      if (m_beat[a].user !== exp_user || m_beat[a].last !== exp_last) begin
        $display("Fail %0t: accel %0d beat %0d user %0d last %b, expected %0d %b", $time, a,
                 got_beats[a], m_beat[a].user, m_beat[a].last, exp_user, exp_last);
        error_count++;
      end
      got_beats[a]++;
    end
  endtask

  // Handshakes are sampled mid-cycle where valid and ready are settled
  always @(negedge clk) begin
    for (int i = 0; i < ACCELS; i++) begin
      if (!rst && m_valid[i] && m_ready[i] && !ignore_beats[i]) begin
        check_beat(i);
      end
    end
  end

  // Ready mode is taken at the edge, the new pattern goes out 2 ns later
  always @(posedge clk) begin : drive_ready
    logic              use_random;
    logic [ACCELS-1:0] fixed_now;
    use_random = ready_random;
    fixed_now  = ready_fixed;
    #2;
    if (use_random) begin
      for (int i = 0; i < ACCELS; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        m_ready[i] = lfsr_state[0];
      end
    end else begin
      m_ready = fixed_now;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  // One-cycle descriptor strobe, expected beats recorded first
  task automatic send_desc(input int a, input logic [11:0] addr, input logic [9:0] len);
    exp_addr[a]   = addr;
    exp_len[a]    = len;
    exp_beats[a]  = (int'(len) + 15) / 16;
    got_beats[a]  = 0;
    desc.accel_id = rd_dma_cfg_pkg::DEST_WIDTH'(a);
    desc.addr     = addr;
    desc.len      = len;
    desc_valid    = 1'b1;
    next_cycle();
    desc_valid    = 1'b0;
  endtask

  task automatic wait_done(input int a);
    while (got_beats[a] < exp_beats[a]) begin
      next_cycle();
    end
  endtask

  task automatic check_status(input string what, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic report_test(input string name);
    if (error_count == errors_before) begin
      pass_count++;
      $display("%s: ok", name);
    end else begin
      fail_count++;
      $display("%s: failed", name);
    end
    errors_before = error_count;
  endtask

  task automatic test_aligned_read();
    // An idle engine issues no bank reads
    if (bank0_rd.en !== 1'b0 || bank1_rd.en !== 1'b0) begin
      $display("Fail %0t: bank read enables %b %b while idle, expected 0 0", $time,
               bank0_rd.en, bank1_rd.en);
      error_count++;
    end
    send_desc(0, 12'h100, 10'd16);
    wait_done(0);
    check_status("accel_busy", accel_busy, 4'b0000);
    check_status("m_valid", m_valid, 4'b0000);
    check_status("desc_error", desc_error, 4'b0000);
    report_test("aligned 16-byte read");
  endtask

  task automatic test_unaligned_read();
    send_desc(1, 12'h035, 10'd40);
    wait_done(1);
    // Leave room for a stray fourth beat to show up
    repeat (8) next_cycle();
    check_status("accel_busy", accel_busy, 4'b0000);
    report_test("unaligned read at 0x35");
  endtask

  task automatic test_all_streams();
    ready_random = 1'b1;
    send_desc(0, 12'h200, 10'd64);
    send_desc(1, 12'h013, 10'd50);
    send_desc(2, 12'h3f8, 10'd33);
    send_desc(3, 12'h087, 10'd16);
    for (int a = 0; a < ACCELS; a++) begin
      wait_done(a);
    end
    ready_random = 1'b0;
    next_cycle();
    check_status("accel_busy", accel_busy, 4'b0000);
    report_test("four streams with random ready");
  endtask

  task automatic test_busy_error();
    // The second descriptor replaces the first, so its data is not scored
    ignore_beats[3] = 1'b1;
    send_desc(3, 12'h140, 10'd160);
    while (!accel_busy[3]) begin
      next_cycle();
    end
    send_desc(3, 12'h1c0, 10'd32);
    check_status("desc_error", desc_error, 4'b1000);
    while (accel_busy[3]) begin
      next_cycle();
    end
    repeat (10) next_cycle();
    check_status("desc_error", desc_error, 4'b1000);
    ignore_beats[3] = 1'b0;
    report_test("descriptor while busy");
  endtask

  task automatic test_stop_flush();
    ready_fixed = 4'b1011;
    send_desc(2, 12'h400, 10'd320);
    while (!m_valid[2]) begin
      next_cycle();
    end
    repeat (10) next_cycle();
    accel_stop = 4'b0100;
    next_cycle();
    accel_stop = 4'b0000;
    repeat (4) next_cycle();
    if (m_valid[2] !== 1'b0 || accel_busy[2] !== 1'b0) begin
      $display("Fail %0t: after stop m_valid %b busy %b, expected 0 0", $time,
               m_valid[2], accel_busy[2]);
      error_count++;
    end
    ready_fixed = 4'b1111;
    next_cycle();
    send_desc(2, 12'h0a9, 10'd45);
    wait_done(2);
    check_status("accel_busy", accel_busy, 4'b0000);
    check_status("desc_error", desc_error, 4'b1000);
    report_test("stop with ready held low");
  endtask

  initial begin
    rst           = 1'b1;
    desc          = '0;
    desc_valid    = 1'b0;
    accel_stop    = '0;
    m_ready       = '1;
    ready_random  = 1'b0;
    ready_fixed   = '1;
    lfsr_state    = 8'd40;
    ignore_beats  = '0;
    cycle_count   = 0;
    error_count   = 0;
    pass_count    = 0;
    fail_count    = 0;
    errors_before = 0;
    for (int a = 0; a < ACCELS; a++) begin
      exp_addr[a]  = '0;
      exp_len[a]   = '0;
      exp_beats[a] = 0;
      got_beats[a] = 0;
    end
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    next_cycle();

    test_aligned_read();
    test_unaligned_read();
    test_all_streams();
    test_busy_error();
    test_stop_flush();

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
design/rd_dma_cfg_pkg.sv
design/rd_dma_types_pkg.sv
design/desc_parse.sv
design/channel_state.sv
design/line_sched.sv
design/line_align.sv
design/accel_fifo.sv
design/accel_rd_dma.sv
sim/spad_model.sv
sim/tb_accel_rd_dma.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_accel_rd_dma
FILELIST = verilog.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
